/* gat_pkg.sv */
package gat_pkg;

  // ==============================
  // Element widths
  // ==============================

  // Weights, attention entries and node features
  localparam int DATA_WIDTH  = 8;

  // Sum of up to 16 products of two 8-bit values
  localparam int WH_WIDTH    = 20;

  // Sum of up to 8 products of WH and one attention entry
  localparam int SCORE_WIDTH = 32;

  // ==============================
  // Shared types
  // ==============================

  typedef logic signed [DATA_WIDTH-1:0]  data_t;
  typedef logic signed [WH_WIDTH-1:0]    wh_t;
  typedef logic signed [SCORE_WIDTH-1:0] score_t;

  // Weight sweep FSM
  typedef enum logic [1:0] {
    SCHED_IDLE,
    SCHED_FETCH,
    SCHED_DONE
  } sched_state_t;

endpackage

/* weight_bram.sv */
`timescale 1ns/1ns

module weight_bram #(
  parameter int  NUM_FEATURE_IN  = 8,
  parameter int  NUM_FEATURE_OUT = 4,
  localparam int DEPTH           = NUM_FEATURE_IN * NUM_FEATURE_OUT + 2 * NUM_FEATURE_OUT,
  localparam int ADDR_W          = $clog2(DEPTH)
) (
  input  logic              clk,

  // Load port, driven from outside
  input  logic              wr_en_i,
  input  logic [ADDR_W-1:0] wr_addr_i,
  input  gat_pkg::data_t    wr_data_i,

  // Sweep port, driven by the scheduler
  input  logic [ADDR_W-1:0] rd_addr_i,
  output gat_pkg::data_t    rd_data_o
);

  import gat_pkg::*;

  // Weight matrix first, attention vector after it
  data_t mem [DEPTH];
  data_t rd_data_q;

  // ==============================
  // Write port
  // ==============================
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  // ==============================
  // Read port, one cycle latency
  // ==============================
  always_ff @(posedge clk) begin
    rd_data_q <= mem[rd_addr_i];
  end

  assign rd_data_o = rd_data_q;

endmodule

/* weight_scheduler.sv */
`timescale 1ns/1ns

module weight_scheduler #(
  parameter int  NUM_FEATURE_IN  = 8,
  parameter int  NUM_FEATURE_OUT = 4,
  localparam int DEPTH           = NUM_FEATURE_IN * NUM_FEATURE_OUT + 2 * NUM_FEATURE_OUT,
  localparam int ADDR_W          = $clog2(DEPTH)
) (
  input  logic                                                      clk,
  input  logic                                                      rst_n,
  input  logic                                                      load_done_i,
  output logic [ADDR_W-1:0]                                         rd_addr_o,
  input  gat_pkg::data_t                                            rd_data_i,
  output gat_pkg::data_t [NUM_FEATURE_IN-1:0][NUM_FEATURE_OUT-1:0]  wgt_mat_o,
  output gat_pkg::data_t [2*NUM_FEATURE_OUT-1:0]                    attn_vec_o,
  output logic                                                      weights_rdy_o
);

  import gat_pkg::*;

  localparam int ROW_W  = $clog2(NUM_FEATURE_IN);
  localparam int COL_W  = $clog2(NUM_FEATURE_OUT);
  localparam int ATTN_W = $clog2(2 * NUM_FEATURE_OUT);

  sched_state_t      state_q;
  logic [ADDR_W-1:0] addr_q;
  logic [ROW_W-1:0]  row_q;
  logic [COL_W-1:0]  col_q;
  logic [ATTN_W-1:0] attn_q;
  logic              in_attn_q;

  // Index copies that line up with the memory read data
  logic              fetch_q;
  logic [ROW_W-1:0]  row_d;
  logic [COL_W-1:0]  col_d;
  logic [ATTN_W-1:0] attn_d;
  logic              in_attn_d;

  data_t [NUM_FEATURE_IN-1:0][NUM_FEATURE_OUT-1:0] wgt_mat_q;
  data_t [2*NUM_FEATURE_OUT-1:0]                   attn_vec_q;
  logic                                            rdy_q;

  // ==============================
  // Sweep FSM and address counter
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= SCHED_IDLE;
      addr_q    <= '0;
      row_q     <= '0;
      col_q     <= '0;
      attn_q    <= '0;
      in_attn_q <= 1'b0;
    end else begin
      case (state_q)
        SCHED_IDLE: begin
          if (load_done_i) begin
            state_q <= SCHED_FETCH;
          end
        end
        SCHED_FETCH: begin
          if (addr_q == ADDR_W'(DEPTH - 1)) begin
            state_q <= SCHED_DONE;
          end else begin
            addr_q <= addr_q + 1'b1;
          end
          // Column runs fastest, attention entries follow the matrix
          if (in_attn_q) begin
            attn_q <= attn_q + 1'b1;
          end else if (col_q == COL_W'(NUM_FEATURE_OUT - 1)) begin
            col_q <= '0;
            if (row_q == ROW_W'(NUM_FEATURE_IN - 1)) begin
              in_attn_q <= 1'b1;
            end else begin
              row_q <= row_q + 1'b1;
            end
          end else begin
            col_q <= col_q + 1'b1;
          end
        end
        default: begin
          // Held until the next reset, later load pulses are ignored
          state_q <= SCHED_DONE;
        end
      endcase
    end
  end

  assign rd_addr_o = addr_q;

  // ==============================
  // Unpack returning words
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_q   <= 1'b0;
      row_d     <= '0;
      col_d     <= '0;
      attn_d    <= '0;
      in_attn_d <= 1'b0;
    end else begin
      fetch_q   <= (state_q == SCHED_FETCH);
      row_d     <= row_q;
      col_d     <= col_q;
      attn_d    <= attn_q;
      in_attn_d <= in_attn_q;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wgt_mat_q  <= '0;
      attn_vec_q <= '0;
      rdy_q      <= 1'b0;
    end else begin
      if (fetch_q) begin
        if (in_attn_d) begin
          attn_vec_q[attn_d] <= rd_data_i;
        end else begin
          wgt_mat_q[row_d][col_d] <= rd_data_i;
        end
      end
      // Raised once the last word has landed
      rdy_q <= (state_q == SCHED_DONE) && !fetch_q;
    end
  end

  assign wgt_mat_o     = wgt_mat_q;
  assign attn_vec_o    = attn_vec_q;
  assign weights_rdy_o = rdy_q;

endmodule

/* feature_transform.sv */
`timescale 1ns/1ns

module feature_transform #(
  parameter int NUM_FEATURE_IN  = 8,
  parameter int NUM_FEATURE_OUT = 4
) (
  input  logic                                                      clk,
  input  logic                                                      rst_n,
  input  logic                                                      node_vld_i,
  input  gat_pkg::data_t [NUM_FEATURE_IN-1:0]                       node_feat_i,
  input  logic                                                      weights_rdy_i,
  input  gat_pkg::data_t [NUM_FEATURE_IN-1:0][NUM_FEATURE_OUT-1:0]  wgt_mat_i,
  output logic                                                      node_busy_o,
  output logic                                                      wh_vld_o,
  output gat_pkg::wh_t [NUM_FEATURE_OUT-1:0]                        wh_o
);

  import gat_pkg::*;

  localparam int IDX_W  = $clog2(NUM_FEATURE_IN);
  localparam int PROD_W = 2 * DATA_WIDTH;

  logic                      accept;
  logic                      busy_q;
  logic                      wh_vld_q;
  logic [IDX_W-1:0]          idx_q;
  data_t [NUM_FEATURE_IN-1:0] feat_q;
  wh_t [NUM_FEATURE_OUT-1:0] acc_q;
  logic signed [PROD_W-1:0]  prod [NUM_FEATURE_OUT];

  // Strobes while busy or before the weights are in are dropped
  assign accept = node_vld_i && weights_rdy_i && !busy_q;

  // ==============================
  // Control
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q   <= 1'b0;
      wh_vld_q <= 1'b0;
      idx_q    <= '0;
    end else begin
      wh_vld_q <= 1'b0;
      if (accept) begin
        busy_q <= 1'b1;
        idx_q  <= '0;
      end else if (busy_q) begin
        if (idx_q == IDX_W'(NUM_FEATURE_IN - 1)) begin
          busy_q   <= 1'b0;
          wh_vld_q <= 1'b1;
        end else begin
          idx_q <= idx_q + 1'b1;
        end
      end
    end
  end

  // ==============================
  // Multiply-accumulate
  // ==============================

  // One input feature against its whole weight row
  always_comb begin
    for (int c = 0; c < NUM_FEATURE_OUT; c++) begin
      prod[c] = $signed(feat_q[idx_q]) * $signed(wgt_mat_i[idx_q][c]);
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      feat_q <= node_feat_i;
      acc_q  <= '0;
    end else if (busy_q) begin
      for (int c = 0; c < NUM_FEATURE_OUT; c++) begin
        acc_q[c] <= acc_q[c] + wh_t'(prod[c]);
      end
    end
  end

  assign node_busy_o = busy_q;
  assign wh_vld_o    = wh_vld_q;
  // Final sums stay put until the next accepted node
  assign wh_o        = acc_q;

endmodule

/* attn_score.sv */
`timescale 1ns/1ns

module attn_score #(
  parameter int NUM_FEATURE_OUT = 4
) (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    wh_vld_i,
  input  gat_pkg::wh_t [NUM_FEATURE_OUT-1:0]      wh_i,
  input  gat_pkg::data_t [2*NUM_FEATURE_OUT-1:0]  attn_vec_i,
  output logic                                    score_vld_o,
  output gat_pkg::wh_t [NUM_FEATURE_OUT-1:0]      wh_o,
  output gat_pkg::score_t                         e_src_o,
  output gat_pkg::score_t                         e_dst_o
);

  import gat_pkg::*;

  localparam int PROD_W = WH_WIDTH + DATA_WIDTH;

  logic signed [PROD_W-1:0]  p_src_q [NUM_FEATURE_OUT];
  logic signed [PROD_W-1:0]  p_dst_q [NUM_FEATURE_OUT];
  logic                      vld1_q;
  logic                      vld2_q;
  wh_t [NUM_FEATURE_OUT-1:0] wh1_q;
  wh_t [NUM_FEATURE_OUT-1:0] wh2_q;
  score_t                    sum_src;
  score_t                    sum_dst;
  score_t                    e_src_q;
  score_t                    e_dst_q;

  // ==============================
  // Valid pipe
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld1_q <= 1'b0;
      vld2_q <= 1'b0;
    end else begin
      vld1_q <= wh_vld_i;
      vld2_q <= vld1_q;
    end
  end

  // Stage one, first half of a for source, second half for destination
  always_ff @(posedge clk) begin
    wh1_q <= wh_i;
    for (int j = 0; j < NUM_FEATURE_OUT; j++) begin
      p_src_q[j] <= $signed(wh_i[j]) * $signed(attn_vec_i[j]);
      p_dst_q[j] <= $signed(wh_i[j]) * $signed(attn_vec_i[NUM_FEATURE_OUT+j]);
    end
  end

  always_comb begin
    sum_src = '0;
    sum_dst = '0;
    for (int j = 0; j < NUM_FEATURE_OUT; j++) begin
      sum_src = sum_src + score_t'(p_src_q[j]);
      sum_dst = sum_dst + score_t'(p_dst_q[j]);
    end
  end

  // Stage two
  always_ff @(posedge clk) begin
    wh2_q   <= wh1_q;
    e_src_q <= sum_src;
    e_dst_q <= sum_dst;
  end

  assign score_vld_o = vld2_q;
  assign wh_o        = wh2_q;
  assign e_src_o     = e_src_q;
  assign e_dst_o     = e_dst_q;

endmodule

/* gat_conv2_top.sv */
`timescale 1ns/1ns

module gat_conv2_top #(
  parameter int  NUM_FEATURE_IN  = 8,
  parameter int  NUM_FEATURE_OUT = 4,
  localparam int WGT_DEPTH       = NUM_FEATURE_IN * NUM_FEATURE_OUT + 2 * NUM_FEATURE_OUT,
  localparam int WGT_ADDR_W      = $clog2(WGT_DEPTH)
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 wgt_wr_en_i,
  input  logic [WGT_ADDR_W-1:0]                wgt_wr_addr_i,
  input  gat_pkg::data_t                       wgt_wr_data_i,
  input  logic                                 wgt_load_done_i,
  input  logic                                 node_vld_i,
  input  gat_pkg::data_t [NUM_FEATURE_IN-1:0]  node_feat_i,
  output logic                                 weights_rdy_o,
  output logic                                 node_busy_o,
  output logic                                 score_vld_o,
  output gat_pkg::wh_t [NUM_FEATURE_OUT-1:0]   wh_o,
  output gat_pkg::score_t                      e_src_o,
  output gat_pkg::score_t                      e_dst_o
);

  import gat_pkg::*;

  logic [WGT_ADDR_W-1:0]                           rd_addr;
  data_t                                           rd_data;
  data_t [NUM_FEATURE_IN-1:0][NUM_FEATURE_OUT-1:0] wgt_mat;
  data_t [2*NUM_FEATURE_OUT-1:0]                   attn_vec;
  logic                                            wh_vld;
  wh_t [NUM_FEATURE_OUT-1:0]                       wh;

  weight_bram #(
    .NUM_FEATURE_IN (NUM_FEATURE_IN),
    .NUM_FEATURE_OUT(NUM_FEATURE_OUT)
  ) weight_bram_i (
    .clk      (clk),
    .wr_en_i  (wgt_wr_en_i),
    .wr_addr_i(wgt_wr_addr_i),
    .wr_data_i(wgt_wr_data_i),
    .rd_addr_i(rd_addr),
    .rd_data_o(rd_data)
  );

  weight_scheduler #(
    .NUM_FEATURE_IN (NUM_FEATURE_IN),
    .NUM_FEATURE_OUT(NUM_FEATURE_OUT)
  ) weight_scheduler_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .load_done_i  (wgt_load_done_i),
    .rd_addr_o    (rd_addr),
    .rd_data_i    (rd_data),
    .wgt_mat_o    (wgt_mat),
    .attn_vec_o   (attn_vec),
    .weights_rdy_o(weights_rdy_o)
  );

  feature_transform #(
    .NUM_FEATURE_IN (NUM_FEATURE_IN),
    .NUM_FEATURE_OUT(NUM_FEATURE_OUT)
  ) feature_transform_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .node_vld_i   (node_vld_i),
    .node_feat_i  (node_feat_i),
    .weights_rdy_i(weights_rdy_o),
    .wgt_mat_i    (wgt_mat),
    .node_busy_o  (node_busy_o),
    .wh_vld_o     (wh_vld),
    .wh_o         (wh)
  );

  attn_score #(
    .NUM_FEATURE_OUT(NUM_FEATURE_OUT)
  ) attn_score_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .wh_vld_i   (wh_vld),
    .wh_i       (wh),
    .attn_vec_i (attn_vec),
    .score_vld_o(score_vld_o),
    .wh_o       (wh_o),
    .e_src_o    (e_src_o),
    .e_dst_o    (e_dst_o)
  );

endmodule

/* tb_clk_gen.sv */
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int HALF_PERIOD  = 5,
  parameter int RESET_CYCLES = 8
) (
  input  logic rst_req_i,
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever begin
      #HALF_PERIOD clk = ~clk;
    end
  end

  // Reset at start and again on every request
  initial begin
    rst_n = 1'b0;
    forever begin
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      while (!rst_req_i) begin
        @(posedge clk);
      end
      rst_n <= 1'b0;
    end
  end

endmodule

/* gat_conv2_checker.sv */
`timescale 1ns/1ns

module gat_conv2_checker #(
  parameter int NUM_FEATURE_OUT = 4
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               score_vld_i,
  input  gat_pkg::wh_t [NUM_FEATURE_OUT-1:0] wh_i,
  input  gat_pkg::score_t                    e_src_i,
  input  gat_pkg::score_t                    e_dst_i,
  input  logic                               exp_push_i,
  input  gat_pkg::wh_t [NUM_FEATURE_OUT-1:0] exp_wh_i,
  input  gat_pkg::score_t                    exp_src_i,
  input  gat_pkg::score_t                    exp_dst_i,
  output int                                 checked_cnt_o,
  output int                                 err_cnt_o
);

  import gat_pkg::*;

  typedef wh_t [NUM_FEATURE_OUT-1:0] wh_vec_t;

  // Expected results in node order
  wh_vec_t wh_q  [$];
  score_t  src_q [$];
  score_t  dst_q [$];
  int      checked_cnt = 0;
  int      err_cnt     = 0;

  always @(posedge clk) begin
    wh_vec_t exp_wh;
    score_t  exp_src;
    score_t  exp_dst;
    if (rst_n && score_vld_i) begin
      if (src_q.size() == 0) begin
        $display("Unexpected score at %0t ns with no node pending", $time);
        err_cnt++;
      end else begin
        exp_wh  = wh_q.pop_front();
        exp_src = src_q.pop_front();
        exp_dst = dst_q.pop_front();
        checked_cnt++;
        for (int c = 0; c < NUM_FEATURE_OUT; c++) begin
          if (wh_i[c] !== exp_wh[c]) begin
            $display("FAIL %0t ns: wh_o[%0d] is %0d, expected %0d", $time, c, wh_i[c],
                     exp_wh[c]);
            err_cnt++;
          end
        end
        if (e_src_i !== exp_src) begin
          $display("FAIL %0t ns: e_src_o is %0d, expected %0d", $time, e_src_i, exp_src);
          err_cnt++;
        end
        if (e_dst_i !== exp_dst) begin
          $display("FAIL %0t ns: e_dst_o is %0d, expected %0d", $time, e_dst_i, exp_dst);
          err_cnt++;
        end
      end
    end
    if (exp_push_i) begin
      wh_q.push_back(exp_wh_i);
      src_q.push_back(exp_src_i);
      dst_q.push_back(exp_dst_i);
    end
  end

  assign checked_cnt_o = checked_cnt;
  assign err_cnt_o     = err_cnt;

endmodule

/* gat_conv2_props.sv */
`timescale 1ns/1ns

module gat_conv2_props #(
  parameter int NUM_FEATURE_IN = 8
) (
  input logic clk,
  input logic rst_n,
  input logic node_vld_i,
  input logic node_busy_i,
  input logic weights_rdy_i,
  input logic score_vld_i
);

  logic accepted;
  int   fail_cnt = 0;

  assign accepted = node_vld_i && weights_rdy_i && !node_busy_i;

  // Ready is a lasting level once the sweep is done
  rdy_held: assert property (@(posedge clk) disable iff (!rst_n)
    ($past(weights_rdy_i) && $past(rst_n)) |-> weights_rdy_i)
    else begin
      fail_cnt++;
      $error("weights_rdy_o fell while out of reset");
    end

  no_score_before_rdy: assert property (@(posedge clk) disable iff (!rst_n)
    score_vld_i |-> weights_rdy_i)
    else begin
      fail_cnt++;
      $error("score_vld_o high while weights_rdy_o is low");
    end

  // Accept sampled on its own edge and score seen one edge after it is set
  fixed_latency: assert property (@(posedge clk) disable iff (!rst_n)
    score_vld_i |-> $past(accepted, NUM_FEATURE_IN + 3))
    else begin
      fail_cnt++;
      $error("score_vld_o without an accepted strobe at the fixed latency");
    end

endmodule

/* gat_conv2_tb.sv */
`timescale 1ns/1ns

module gat_conv2_tb;

  import gat_pkg::*;

  localparam int NUM_FEATURE_IN  = 8;
  localparam int NUM_FEATURE_OUT = 4;
  localparam int DEPTH           = NUM_FEATURE_IN * NUM_FEATURE_OUT + 2 * NUM_FEATURE_OUT;
  localparam int ADDR_W          = $clog2(DEPTH);

  typedef data_t [NUM_FEATURE_IN-1:0] feat_vec_t;
  typedef wh_t [NUM_FEATURE_OUT-1:0]  wh_vec_t;

  logic              clk;
  logic              rst_n;
  logic              rst_req;
  logic              wgt_wr_en;
  logic [ADDR_W-1:0] wgt_wr_addr;
  data_t             wgt_wr_data;
  logic              wgt_load_done;
  logic              node_vld;
  feat_vec_t         node_feat;
  logic              weights_rdy;
  logic              node_busy;
  logic              score_vld;
  wh_vec_t           wh;
  score_t            e_src;
  score_t            e_dst;
  logic              exp_push;
  wh_vec_t           exp_wh;
  score_t            exp_src;
  score_t            exp_dst;
  int                checked_cnt;
  int                chk_err_cnt;
  int                prop_err_cnt;

  // Model copy of the loaded weights and attention vector
  int w_mdl [NUM_FEATURE_IN][NUM_FEATURE_OUT];
  int a_mdl [2*NUM_FEATURE_OUT];
  int tb_err_cnt = 0;
  int pushed_cnt = 0;
  int test_cnt   = 0;
  int err_mark   = 0;

  tb_clk_gen tb_clk_gen_i (
    .rst_req_i(rst_req),
    .clk      (clk),
    .rst_n    (rst_n)
  );

  gat_conv2_top #(
    .NUM_FEATURE_IN (NUM_FEATURE_IN),
    .NUM_FEATURE_OUT(NUM_FEATURE_OUT)
  ) gat_conv2_top_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .wgt_wr_en_i    (wgt_wr_en),
    .wgt_wr_addr_i  (wgt_wr_addr),
    .wgt_wr_data_i  (wgt_wr_data),
    .wgt_load_done_i(wgt_load_done),
    .node_vld_i     (node_vld),
    .node_feat_i    (node_feat),
    .weights_rdy_o  (weights_rdy),
    .node_busy_o    (node_busy),
    .score_vld_o    (score_vld),
    .wh_o           (wh),
    .e_src_o        (e_src),
    .e_dst_o        (e_dst)
  );

  gat_conv2_checker #(
    .NUM_FEATURE_OUT(NUM_FEATURE_OUT)
  ) gat_conv2_checker_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .score_vld_i  (score_vld),
    .wh_i         (wh),
    .e_src_i      (e_src),
    .e_dst_i      (e_dst),
    .exp_push_i   (exp_push),
    .exp_wh_i     (exp_wh),
    .exp_src_i    (exp_src),
    .exp_dst_i    (exp_dst),
    .checked_cnt_o(checked_cnt),
    .err_cnt_o    (chk_err_cnt)
  );

  bind gat_conv2_top gat_conv2_props #(
    .NUM_FEATURE_IN(NUM_FEATURE_IN)
  ) gat_conv2_props_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .node_vld_i   (node_vld_i),
    .node_busy_i  (node_busy_o),
    .weights_rdy_i(weights_rdy_o),
    .score_vld_i  (score_vld_o)
  );

  assign prop_err_cnt = gat_conv2_top_i.gat_conv2_props_i.fail_cnt;

  // Random element with the extremes mixed in
  function automatic data_t rand_elem();
    logic [2:0] pick;
    pick = 3'($urandom);
    if (pick == 3'd0) begin
      return data_t'(8'h80);
    end
    if (pick == 3'd1) begin
      return data_t'(8'h7f);
    end
    return data_t'($urandom);
  endfunction

  task automatic load_weights();
    data_t v;
    for (int a = 0; a < DEPTH; a++) begin
      v = rand_elem();
      if (a < NUM_FEATURE_IN * NUM_FEATURE_OUT) begin
        w_mdl[a / NUM_FEATURE_OUT][a % NUM_FEATURE_OUT] = int'(v);
      end else begin
        a_mdl[a - NUM_FEATURE_IN * NUM_FEATURE_OUT] = int'(v);
      end
      @(posedge clk);
      wgt_wr_en   <= 1'b1;
      wgt_wr_addr <= ADDR_W'(a);
      wgt_wr_data <= v;
    end
    @(posedge clk);
    wgt_wr_en     <= 1'b0;
    wgt_load_done <= 1'b1;
    @(posedge clk);
    wgt_load_done <= 1'b0;
  endtask

  // Model result goes to the checker only for strobes the drop rule accepts
  task automatic send_node(input feat_vec_t feat, input bit accepted);
    wh_vec_t m_wh;
    longint  acc;
    longint  src;
    longint  dst;
    src = 0;
    dst = 0;
    for (int c = 0; c < NUM_FEATURE_OUT; c++) begin
      acc = 0;
      for (int r = 0; r < NUM_FEATURE_IN; r++) begin
        acc += longint'(feat[r]) * w_mdl[r][c];
      end
      m_wh[c] = wh_t'(acc);
      src += acc * a_mdl[c];
      dst += acc * a_mdl[NUM_FEATURE_OUT + c];
    end
    @(posedge clk);
    node_vld  <= 1'b1;
    node_feat <= feat;
    exp_push  <= accepted;
    exp_wh    <= m_wh;
    exp_src   <= score_t'(src);
    exp_dst   <= score_t'(dst);
    if (accepted) begin
      pushed_cnt++;
    end
    @(posedge clk);
    node_vld <= 1'b0;
    exp_push <= 1'b0;
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (rst_n !== 1'b1 && n < 20);
    if (rst_n !== 1'b1) begin
      $display("Timeout: rst_n was not released within 20 cycles");
      tb_err_cnt++;
    end
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (weights_rdy !== 1'b1 && n < DEPTH + 10);
    if (weights_rdy !== 1'b1) begin
      $display("Timeout: weights_rdy_o did not rise within %0d cycles", DEPTH + 10);
      tb_err_cnt++;
    end
  endtask

  // Busy cycles still to come from the current node
  task automatic wait_idle(input int busy_cycles);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (node_busy !== 1'b0 && n < NUM_FEATURE_IN + 10);
    if (node_busy !== 1'b0) begin
      $display("Timeout: node_busy_o stayed high for %0d cycles", NUM_FEATURE_IN + 10);
      tb_err_cnt++;
    end else if (n - 1 != busy_cycles) begin
      $display("FAIL %0t ns: node_busy_o high for %0d cycles, expected %0d", $time,
               n - 1, busy_cycles);
      tb_err_cnt++;
    end
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (checked_cnt != pushed_cnt && n < 2 * NUM_FEATURE_IN + 20);
    if (checked_cnt != pushed_cnt) begin
      $display("Timeout: %0d of %0d expected results never arrived",
               pushed_cnt - checked_cnt, pushed_cnt);
      tb_err_cnt++;
    end
  endtask

  // Window where no result may show up
  task automatic idle_cycles(input int cycles);
    for (int n = 0; n < cycles; n++) begin
      @(negedge clk);
    end
  endtask

  task automatic reset_dut();
    @(posedge clk);
    rst_req <= 1'b1;
    @(posedge clk);
    rst_req <= 1'b0;
    @(negedge clk);
    if (weights_rdy !== 1'b0) begin
      $display("FAIL %0t ns: weights_rdy_o still high during reset", $time);
      tb_err_cnt++;
    end
    wait_reset_release();
  endtask

  task automatic finish_test(input string name);
    int errs;
    errs = tb_err_cnt + chk_err_cnt + prop_err_cnt - err_mark;
    test_cnt++;
    if (errs == 0) begin
      $display("test %0d %s: pass", test_cnt, name);
    end else begin
      $display("test %0d %s: fail with %0d errors", test_cnt, name, errs);
    end
    err_mark = tb_err_cnt + chk_err_cnt + prop_err_cnt;
  endtask

  // ==============================
  // Test sequence
  // ==============================
  initial begin
    feat_vec_t f;
    int        total;
    void'($urandom(32'h9205_ae82));
    rst_req       = 1'b0;
    wgt_wr_en     = 1'b0;
    wgt_wr_addr   = '0;
    wgt_wr_data   = '0;
    wgt_load_done = 1'b0;
    node_vld      = 1'b0;
    node_feat     = '0;
    exp_push      = 1'b0;
    exp_wh        = '0;
    exp_src       = '0;
    exp_dst       = '0;
    wait_reset_release();

    // Weights not loaded yet, so all of these are dropped
    for (int i = 0; i < 3; i++) begin
      for (int r = 0; r < NUM_FEATURE_IN; r++) begin
        f[r] = rand_elem();
      end
      send_node(f, 1'b0);
    end
    idle_cycles(NUM_FEATURE_IN + 5);
    finish_test("strobes before ready");

    load_weights();
    wait_ready();
    finish_test("weight load and ready");

    for (int i = 0; i < 20; i++) begin
      for (int r = 0; r < NUM_FEATURE_IN; r++) begin
        f[r] = rand_elem();
      end
      send_node(f, 1'b1);
      wait_idle(NUM_FEATURE_IN);
    end
    wait_drained();
    finish_test("random nodes");

    for (int k = 0; k < 4; k++) begin
      for (int r = 0; r < NUM_FEATURE_IN; r++) begin
        case (k)
          0:       f[r] = data_t'(8'h80);
          1:       f[r] = data_t'(8'h7f);
          2:       f[r] = (r % 2 == 0) ? data_t'(8'h80) : data_t'(8'h7f);
          default: f[r] = (r % 2 == 0) ? data_t'(8'h7f) : data_t'(8'h80);
        endcase
      end
      send_node(f, 1'b1);
      wait_idle(NUM_FEATURE_IN);
    end
    wait_drained();
    finish_test("extreme features");

    // Second strobe lands while the first node is still busy
    for (int r = 0; r < NUM_FEATURE_IN; r++) begin
      f[r] = rand_elem();
    end
    send_node(f, 1'b1);
    f[0] = ~f[0];
    send_node(f, 1'b0);
    wait_idle(NUM_FEATURE_IN - 2);
    wait_drained();
    idle_cycles(NUM_FEATURE_IN + 5);
    if (checked_cnt != pushed_cnt || weights_rdy !== 1'b1) begin
      $display("FAIL %0t ns: %0d results for %0d accepted nodes, ready %0b", $time,
               checked_cnt, pushed_cnt, weights_rdy);
      tb_err_cnt++;
    end
    finish_test("strobe while busy");

    reset_dut();
    load_weights();
    wait_ready();
    for (int i = 0; i < 10; i++) begin
      for (int r = 0; r < NUM_FEATURE_IN; r++) begin
        f[r] = rand_elem();
      end
      send_node(f, 1'b1);
      wait_idle(NUM_FEATURE_IN);
    end
    wait_drained();
    finish_test("reset and reload");

    total = tb_err_cnt + chk_err_cnt + prop_err_cnt;
    $display("%0d tests, %0d results checked, %0d errors", test_cnt, checked_cnt, total);
    if (total == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* files.f */
gat_pkg.sv
weight_bram.sv
weight_scheduler.sv
feature_transform.sv
attn_score.sv
gat_conv2_top.sv
tb_clk_gen.sv
gat_conv2_checker.sv
gat_conv2_props.sv
gat_conv2_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module gat_conv2_tb -f files.f -o gat_conv2_sim

out=$(./obj_dir/gat_conv2_sim 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "TESTS PASSED"; then
  exit 0
fi
exit 1
